// File: ifu_top.f
ifu_pkg.sv
ifu_stage_reg.sv
ifu_pc_gen.sv
ifu_icache.sv
ifu_axil_reader.sv
ifu_predecode.sv
ifu_top.sv
tb_axil_mem.sv
tb_ifu_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_ifu_top -f ifu_top.f -o tb_ifu_top
out="$(./obj_dir/tb_ifu_top)"
printf '%s\n' "$out"
echo "$out" | grep -q "Simulation PASSED"

// File: tb_ifu_top.sv
module tb_ifu_top;

  localparam int NUM_INSTS  = 400;
  localparam int IDLE_LIMIT = 300;

  logic                clk, rst;
  logic [31:0]         m_araddr, m_rdata;
  logic                m_arvalid, m_arready, m_rvalid, m_rready;
  logic                redirect_valid;
  logic [31:0]         redirect_pc;
  logic                inst_valid, inst_ready;
  ifu_pkg::fetch_rsp_t inst, held_inst;

  logic [31:0] model_mem [256]; // reference copy of the memory.
  logic [31:0] exp_pc, redir_target, ar_held_addr;
  logic        redir_pending, held, ar_held, r_pending;
  int          errors, accepted, idle, redir_cnt;

  ifu_top uut (
    .clk(clk), .rst(rst),
    .m_araddr_o(m_araddr), .m_arvalid_o(m_arvalid), .m_arready_i(m_arready),
    .m_rdata_i(m_rdata), .m_rvalid_i(m_rvalid), .m_rready_o(m_rready),
    .redirect_valid_i(redirect_valid), .redirect_pc_i(redirect_pc),
    .inst_valid_o(inst_valid), .inst_ready_i(inst_ready), .inst_o(inst)
  );

  tb_axil_mem u_mem (
    .clk(clk), .rst(rst), .araddr_i(m_araddr), .arvalid_i(m_arvalid), .arready_o(m_arready),
    .rdata_o(m_rdata), .rvalid_o(m_rvalid), .rready_i(m_rready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic is_stop_op(input logic [31:0] word);
    case (word[6:0])
      ifu_pkg::OP_JAL, ifu_pkg::OP_JALR, ifu_pkg::OP_BRANCH,
      ifu_pkg::OP_SYSTEM, ifu_pkg::OP_LOAD: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] random_inst();
    logic [31:0] r;
    logic [6:0]  op;
    r = $urandom;
    case (r[4:0])
      5'd0, 5'd1: op = ifu_pkg::OP_JAL;
      5'd2, 5'd3: op = ifu_pkg::OP_JALR;
      5'd4, 5'd5: op = ifu_pkg::OP_BRANCH;
      5'd6:       op = ifu_pkg::OP_SYSTEM;
      5'd7:       op = ifu_pkg::OP_LOAD;
      5'd8:       return ifu_pkg::INST_FENCE_I;
      default:    op = 7'b0010011; // op-imm.
    endcase
    return {r[31:7], op};
  endfunction

  // pc+4 and pc+8 may already be past the cache, so new words start at pc+12.
  task automatic rewrite_after_fence(input logic [31:0] pc);
    logic [31:0] addr;
    logic [31:0] word;
    addr = pc + 32'd12;
    repeat (4) begin
      word                  = random_inst();
      model_mem[addr[9:2]]  = word;
      u_mem.mem[addr[9:2]]  = word;
      addr                  = addr + 32'd4;
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r              = $urandom;
    inst_ready     = (r[1:0] != 2'b00);
    redirect_valid = 1'b0;
    if (redir_pending && redir_cnt == 0) begin
      redirect_valid = 1'b1;
      redirect_pc    = redir_target;
      exp_pc         = redir_target;
      redir_pending  = 1'b0;
    end else if (redir_pending) begin
      redir_cnt--;
    end
  endtask

  task automatic check_outputs();
    logic [31:0] word;
    logic [31:0] r;
    if (held && !inst_valid) begin
      $display("inst_valid_o dropped while the instruction was stalled");
      errors++;
    end else if (held && inst !== held_inst) begin
      $display("[ERROR] stall_hold: expected %h, actual %h", held_inst, inst);
      errors++;
    end
    if (ar_held && !m_arvalid) begin
      $display("m_arvalid_o dropped before m_arready_i");
      errors++;
    end else if (ar_held && m_araddr !== ar_held_addr) begin
      $display("[ERROR] ar_hold: expected %h, actual %h", ar_held_addr, m_araddr);
      errors++;
    end
    if (m_rready !== r_pending) begin
      $display("[ERROR] rready: expected %b, actual %b", r_pending, m_rready);
      errors++;
    end
    if (m_arvalid && m_arready) begin
      r_pending = 1'b1; // data phase opens after the address handshake.
    end else if (m_rvalid && m_rready) begin
      r_pending = 1'b0;
    end
    held         = inst_valid && !inst_ready;
    held_inst    = inst;
    ar_held      = m_arvalid && !m_arready;
    ar_held_addr = m_araddr;
    if (!(inst_valid && inst_ready)) begin
      idle++;
    end else begin
      idle = 0;
      accepted++;
      word = model_mem[inst.pc[9:2]];
      if (redir_pending) begin
        $display("instruction at pc %h accepted before the redirect", inst.pc);
        errors++;
      end
      if (inst.pc !== exp_pc) begin
        $display("[ERROR] pc_sequence: expected %h, actual %h", exp_pc, inst.pc);
        errors++;
      end
      if (inst.inst !== word) begin
        $display("[ERROR] inst_data: expected %h, actual %h", word, inst.inst);
        errors++;
      end
      if (inst.stop !== is_stop_op(word)) begin
        $display("[ERROR] stop_bit: expected %b, actual %b", is_stop_op(word), inst.stop);
        errors++;
      end
      if (is_stop_op(word)) begin
        r             = $urandom;
        redir_pending = 1'b1;
        redir_cnt     = r % 6;
        redir_target  = {22'b0, r[15:8], 2'b00}; // word aligned, below 0x400.
      end else begin
        exp_pc = exp_pc + 32'd4;
        if (word == ifu_pkg::INST_FENCE_I) begin
          rewrite_after_fence(inst.pc);
        end
      end
    end
  endtask

  initial begin
    logic [7:0] idx;
    void'($urandom(32'hccd6));
    rst            = 1'b1;
    inst_ready     = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    exp_pc         = ifu_pkg::PC_INIT;
    redir_pending  = 1'b0;
    held           = 1'b0;
    ar_held        = 1'b0;
    r_pending      = 1'b0;
    errors         = 0;
    accepted       = 0;
    idle           = 0;
    idx            = '0;
    repeat (256) begin
      model_mem[idx] = random_inst();
      u_mem.mem[idx] = model_mem[idx];
      idx++;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    while (accepted < NUM_INSTS && idle < IDLE_LIMIT) begin
      drive_inputs();
      @(negedge clk); // outputs settled, transfer happens at the next edge.
      check_outputs();
      @(posedge clk);
      #1;
    end
    if (idle >= IDLE_LIMIT) begin
      $display("timeout: no instruction accepted for %0d cycles", IDLE_LIMIT);
      errors++;
    end
    $display("accepted %0d instructions, %0d errors", accepted, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: tb_axil_mem.sv
module tb_axil_mem (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [31:0] rdata_o,
  output logic        rvalid_o,
  input  logic        rready_i
);

  logic [31:0] mem [256]; // filled and rewritten by the testbench.
  logic        rst_seen, ar_fire, r_fire, pending;
  logic [31:0] addr_q, delay, r;

  initial begin
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    pending   = 1'b0;
    delay     = '0;
    addr_q    = '0;
    forever begin
      @(negedge clk);
      rst_seen = rst;
      ar_fire  = arvalid_i && arready_o; // both handshakes complete at the next edge.
      r_fire   = rvalid_o && rready_i;
      if (ar_fire) begin
        addr_q = araddr_i;
      end
      @(posedge clk);
      #1;
      r = $urandom;
      if (rst_seen) begin
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        pending   = 1'b0;
      end else begin
        if (r_fire) begin
          rvalid_o = 1'b0;
        end
        if (ar_fire) begin
          arready_o = 1'b0;
          pending   = 1'b1;
          delay     = r % 4;
        end else if (pending && delay != 0) begin
          delay = delay - 32'd1;
        end else if (pending) begin
          rvalid_o = 1'b1;
          rdata_o  = mem[addr_q[9:2]]; // 256 words, aliased above 0x400.
          pending  = 1'b0;
        end else if (!rvalid_o) begin
          arready_o = r[2];
        end
      end
    end
  end

endmodule

// File: ifu_top.sv
module ifu_top (
  input  logic                       clk,
  input  logic                       rst,
  output logic [ifu_pkg::ADDR_W-1:0] m_araddr_o,
  output logic                       m_arvalid_o,
  input  logic                       m_arready_i,
  input  logic [ifu_pkg::DATA_W-1:0] m_rdata_i,
  input  logic                       m_rvalid_i,
  output logic                       m_rready_o,
  input  logic                       redirect_valid_i,
  input  logic [ifu_pkg::ADDR_W-1:0] redirect_pc_i,
  output logic                       inst_valid_o,
  input  logic                       inst_ready_i,
  output ifu_pkg::fetch_rsp_t        inst_o
);

  ifu_pkg::fetch_req_t        pc_req;
  ifu_pkg::fetch_req_t        s1_req;
  ifu_pkg::fetch_rsp_t        ic_rsp;
  ifu_pkg::fetch_rsp_t        s2_rsp;
  logic                       pc_valid;
  logic                       pc_ready;
  logic                       s1_valid;
  logic                       s1_ready;
  logic                       ic_valid;
  logic                       ic_ready;
  logic                       s2_valid;
  logic                       s2_ready;
  logic                       flush;
  logic                       invalidate;
  logic                       rd_req;
  logic                       rd_done;
  logic [ifu_pkg::ADDR_W-1:0] rd_addr;
  logic [ifu_pkg::DATA_W-1:0] rd_data;

  ifu_pc_gen u_pc_gen (
    .clk, .rst, .flush_i(flush),
    .redirect_valid_i, .redirect_pc_i,
    .req_valid_o(pc_valid), .req_ready_i(pc_ready), .req_o(pc_req)
  );

  ifu_stage_reg #(.payload_t(ifu_pkg::fetch_req_t)) u_s1 (
    .clk, .rst, .flush_i(flush),
    .in_valid_i(pc_valid), .in_ready_o(pc_ready), .in_data_i(pc_req),
    .out_valid_o(s1_valid), .out_ready_i(s1_ready), .out_data_o(s1_req)
  );

  ifu_icache u_icache (
    .clk, .rst, .flush_i(flush), .invalidate_i(invalidate),
    .req_valid_i(s1_valid), .req_ready_o(s1_ready), .req_i(s1_req),
    .rsp_valid_o(ic_valid), .rsp_ready_i(ic_ready), .rsp_o(ic_rsp),
    .rd_req_o(rd_req), .rd_addr_o(rd_addr), .rd_done_i(rd_done), .rd_data_i(rd_data)
  );

  ifu_axil_reader u_reader (
    .clk, .rst,
    .rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_done_o(rd_done), .rd_data_o(rd_data),
    .m_araddr_o, .m_arvalid_o, .m_arready_i, .m_rdata_i, .m_rvalid_i, .m_rready_o
  );

  ifu_stage_reg #(.payload_t(ifu_pkg::fetch_rsp_t)) u_s2 (
    .clk, .rst, .flush_i(flush),
    .in_valid_i(ic_valid), .in_ready_o(ic_ready), .in_data_i(ic_rsp),
    .out_valid_o(s2_valid), .out_ready_i(s2_ready), .out_data_o(s2_rsp)
  );

  ifu_predecode u_predecode (
    .clk, .rst,
    .in_valid_i(s2_valid), .in_ready_o(s2_ready), .in_i(s2_rsp),
    .inst_valid_o, .inst_ready_i, .inst_o,
    .flush_o(flush), .invalidate_o(invalidate)
  );

endmodule

// File: ifu_predecode.sv
module ifu_predecode (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  ifu_pkg::fetch_rsp_t in_i,
  output logic                inst_valid_o,
  input  logic                inst_ready_i,
  output ifu_pkg::fetch_rsp_t inst_o,
  output logic                flush_o,
  output logic                invalidate_o
);

  logic flush_q;
  logic invalidate_q;
  logic xfer;
  logic is_fence_i;

  assign is_fence_i = (in_i.inst == ifu_pkg::INST_FENCE_I);

  // hold off the next instruction while the flush is taken.
  assign inst_valid_o = in_valid_i && !flush_q;
  assign in_ready_o   = inst_ready_i && !flush_q;
  assign inst_o       = in_i;

  assign xfer = in_valid_i && in_ready_o;

  assign flush_o      = flush_q;
  assign invalidate_o = invalidate_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      flush_q      <= 1'b0;
      invalidate_q <= 1'b0;
    end else begin
      flush_q      <= xfer && in_i.stop;
      invalidate_q <= xfer && is_fence_i; // fetch keeps running.
    end
  end

endmodule

// File: ifu_axil_reader.sv
module ifu_axil_reader (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rd_req_i,
  input  logic [ifu_pkg::ADDR_W-1:0] rd_addr_i,
  output logic                       rd_done_o,
  output logic [ifu_pkg::DATA_W-1:0] rd_data_o,
  output logic [ifu_pkg::ADDR_W-1:0] m_araddr_o,
  output logic                       m_arvalid_o,
  input  logic                       m_arready_i,
  input  logic [ifu_pkg::DATA_W-1:0] m_rdata_i,
  input  logic                       m_rvalid_i,
  output logic                       m_rready_o
);

  typedef enum logic [1:0] {
    RD_DONE,
    RD_ADDR,
    RD_DATA
  } rd_state_e;

  rd_state_e                  state_q;
  logic                       done_q;
  logic [ifu_pkg::ADDR_W-1:0] addr_q;
  logic [ifu_pkg::DATA_W-1:0] data_q;

  assign m_araddr_o  = addr_q;
  assign m_arvalid_o = (state_q == RD_ADDR);
  assign m_rready_o  = (state_q == RD_DATA);

  assign rd_done_o = done_q;
  assign rd_data_o = data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RD_DONE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        RD_DONE: begin
          if (rd_req_i) begin
            state_q <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (m_arready_i) begin
            state_q <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (m_rvalid_i) begin
            state_q <= RD_DONE;
            done_q  <= 1'b1; // single-cycle pulse.
          end
        end
        default: state_q <= RD_DONE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == RD_DONE) && rd_req_i) begin
      addr_q <= {rd_addr_i[ifu_pkg::ADDR_W-1:2], 2'b00};
    end
    if (m_rready_o && m_rvalid_i) begin
      data_q <= m_rdata_i;
    end
  end

  a_ar_hold: assert property (
    @(posedge clk) disable iff (rst)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o)
  );

endmodule

// File: ifu_icache.sv
module ifu_icache (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       flush_i,
  input  logic                       invalidate_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  ifu_pkg::fetch_req_t        req_i,
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output ifu_pkg::fetch_rsp_t        rsp_o,
  output logic                       rd_req_o,
  output logic [ifu_pkg::ADDR_W-1:0] rd_addr_o,
  input  logic                       rd_done_i,
  input  logic [ifu_pkg::DATA_W-1:0] rd_data_i
);

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_FIRST,
    RF_SECOND
  } rf_state_e;

  // arrays
  logic [ifu_pkg::DATA_W-1:0]    data_q [ifu_pkg::L1I_SETS][ifu_pkg::L1I_LINE_WORDS];
  logic [ifu_pkg::L1I_TAG_W-1:0] tag_q  [ifu_pkg::L1I_SETS];
  logic [ifu_pkg::L1I_SETS-1:0]  line_valid_q;

  // lookup slot
  logic                lk_valid_q;
  ifu_pkg::fetch_req_t lk_req_q;

  // refill control
  rf_state_e                     rf_q;
  logic                          rf_wait_q; // word request is on the bus.
  logic                          rf_stale_q; // invalidated while filling.
  logic [ifu_pkg::L1I_TAG_W-1:0] rf_tag_q;
  logic [ifu_pkg::L1I_IDX_W-1:0] rf_idx_q;

  logic [ifu_pkg::L1I_TAG_W-1:0] lk_tag;
  logic [ifu_pkg::L1I_IDX_W-1:0] lk_idx;
  logic                          lk_off;
  logic                          tag_match;
  logic                          hit;
  logic                          miss;
  logic                          rsp_fire;
  logic [ifu_pkg::DATA_W-1:0]    rd_word;
  logic [6:0]                    opcode;

  assign lk_tag = lk_req_q.pc[ifu_pkg::ADDR_W-1:ifu_pkg::L1I_TAG_LSB];
  assign lk_idx = lk_req_q.pc[ifu_pkg::L1I_TAG_LSB-1:ifu_pkg::L1I_IDX_LSB];
  assign lk_off = lk_req_q.pc[ifu_pkg::L1I_IDX_LSB-1];

  assign tag_match = line_valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
  assign hit       = lk_valid_q && (rf_q == RF_IDLE) && tag_match;
  assign miss      = lk_valid_q && (rf_q == RF_IDLE) && !tag_match && !flush_i;
  assign rsp_fire  = hit && rsp_ready_i;

  assign rd_word = data_q[lk_idx][lk_off];
  assign opcode  = rd_word[6:0];

  assign rsp_valid_o = hit;
  assign rsp_o = '{
    pc:   lk_req_q.pc,
    inst: rd_word,
    stop: opcode inside {ifu_pkg::OP_JAL, ifu_pkg::OP_JALR, ifu_pkg::OP_BRANCH,
                         ifu_pkg::OP_SYSTEM, ifu_pkg::OP_LOAD}
  };

  // no new lookup while a refill owns the line.
  assign req_ready_o = (rf_q == RF_IDLE) && (!lk_valid_q || rsp_fire);

  assign rd_req_o  = (rf_q != RF_IDLE) && !rf_wait_q;
  assign rd_addr_o = {rf_tag_q, rf_idx_q, rf_q == RF_SECOND, 2'b00}; // even word first.

  always_ff @(posedge clk) begin
    if (rst) begin
      lk_valid_q   <= 1'b0;
      rf_q         <= RF_IDLE;
      rf_wait_q    <= 1'b0;
      rf_stale_q   <= 1'b0;
      line_valid_q <= '0;
    end else begin
      if (flush_i) begin
        lk_valid_q <= 1'b0; // a running refill still completes.
      end else if (req_valid_i && req_ready_o) begin
        lk_valid_q <= 1'b1;
      end else if (rsp_fire) begin
        lk_valid_q <= 1'b0;
      end
      if (rd_req_o) begin
        rf_wait_q <= 1'b1;
      end
      case (rf_q)
        RF_IDLE: begin
          if (miss) begin
            rf_q                 <= RF_FIRST;
            rf_stale_q           <= 1'b0;
            line_valid_q[lk_idx] <= 1'b0;
          end
        end
        RF_FIRST: begin
          if (rd_done_i) begin
            rf_q      <= RF_SECOND;
            rf_wait_q <= 1'b0;
          end
        end
        RF_SECOND: begin
          if (rd_done_i) begin
            rf_q      <= RF_IDLE;
            rf_wait_q <= 1'b0;
            if (!rf_stale_q) begin
              line_valid_q[rf_idx_q] <= 1'b1;
            end
          end
        end
        default: rf_q <= RF_IDLE;
      endcase
      if (invalidate_i) begin
        line_valid_q <= '0; // overrides a line completing in this cycle.
        if (rf_q != RF_IDLE) begin
          rf_stale_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      lk_req_q <= req_i;
    end
    if (miss) begin
      rf_tag_q <= lk_tag;
      rf_idx_q <= lk_idx;
    end
    if (rd_done_i && (rf_q == RF_FIRST)) begin
      data_q[rf_idx_q][0] <= rd_data_i;
    end
    if (rd_done_i && (rf_q == RF_SECOND)) begin
      data_q[rf_idx_q][1] <= rd_data_i;
      tag_q[rf_idx_q]     <= rf_tag_q;
    end
  end

  a_no_req_idle: assert property (
    @(posedge clk) disable iff (rst)
    (rf_q == RF_IDLE) |-> !rd_req_o
  );

endmodule

// File: ifu_pc_gen.sv
module ifu_pc_gen (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      flush_i,
  input  logic                      redirect_valid_i,
  input  logic [ifu_pkg::ADDR_W-1:0] redirect_pc_i,
  output logic                      req_valid_o,
  input  logic                      req_ready_i,
  output ifu_pkg::fetch_req_t       req_o
);

  logic                       wait_q;
  logic [ifu_pkg::ADDR_W-1:0] pc_q;
  logic                       waiting;
  logic                       redirect;

  // a flush puts the stage into waiting within the same cycle.
  assign waiting  = wait_q || flush_i;
  assign redirect = waiting && redirect_valid_i;

  assign req_valid_o = !waiting;
  assign req_o       = '{pc: pc_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_q <= 1'b0;
      pc_q   <= ifu_pkg::PC_INIT;
    end else if (redirect) begin
      wait_q <= 1'b0;
      pc_q   <= redirect_pc_i; // resume at the target.
    end else if (flush_i) begin
      wait_q <= 1'b1;
    end else if (req_valid_o && req_ready_i) begin
      pc_q <= pc_q + ifu_pkg::ADDR_W'(4);
    end
  end

endmodule

// File: ifu_stage_reg.sv
module ifu_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     flush_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q;
  payload_t data_q;

  // take a new item when empty or when the held one leaves now.
  assign in_ready_o  = !valid_q || out_ready_i;
  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      valid_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  a_hold_stable: assert property (
    @(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(out_data_o)
  );

endmodule

// File: ifu_pkg.sv
package ifu_pkg;

  localparam int ADDR_W = 32; // pc and bus address width.
  localparam int DATA_W = 32; // instruction and bus data width.

  localparam logic [ADDR_W-1:0] PC_INIT = 32'h0000_0000;

  // instruction cache geometry.
  localparam int L1I_SETS       = 4;
  localparam int L1I_IDX_W      = 2;
  localparam int L1I_LINE_WORDS = 2;
  localparam int L1I_TAG_W      = 27;
  localparam int L1I_IDX_LSB    = 3; // word offset sits just below, at pc bit 2.
  localparam int L1I_TAG_LSB    = L1I_IDX_LSB + L1I_IDX_W;

  // opcodes that stop fetch until a redirect.
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;

  localparam logic [DATA_W-1:0] INST_FENCE_I = 32'h0000_100f;

  // request from pc_gen to the cache.
  typedef struct packed {
    logic [ADDR_W-1:0] pc;
  } fetch_req_t;

  // cache response, also the instruction handed to the decoder.
  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] inst;
    logic              stop; // jump, branch, system or load.
  } fetch_rsp_t;

endpackage
